//--- src/projector_pkg.sv
package projector_pkg;

   // Image geometry
   localparam int NUM_ROWS = 240;
   localparam int NUM_COLS = 320;

   // Mirror return timing, counted in row steps
   localparam int HEADSTART_STEPS = 75;
   localparam int HOLD_STEPS      = 0;

   // Cycles from a row change until the column sweep starts
   localparam int X_SETTLE_CYCLES = 20;

   // Scalar types
   typedef logic [7:0]  row_t;
   typedef logic [8:0]  col_t;
   typedef logic [8:0]  mirror_addr_t;
   typedef logic [31:0] fb_addr_t;
   typedef logic [7:0]  pixel_t;
   typedef logic [1:0]  laser_level_t;

   // Base of the frame in the external memory map
   localparam fb_addr_t FB_BASE = 32'h0090_0000;

   // Y-axis sequencer phases
   typedef enum logic [2:0] {
      SEQ_RETURN    = 3'd0,
      SEQ_HOLD      = 3'd1,
      SEQ_HEADSTART = 3'd2,
      SEQ_DISPLAY   = 3'd3
   } seq_state_t;

   // Row position as seen by the column scanner
   typedef struct packed {
      row_t row;
      logic displaying;
   } row_status_t;

   // Y mirror DAC drive
   typedef struct packed {
      mirror_addr_t ramp;
      logic         dac_wr;
   } mirror_drive_t;

endpackage

//--- src/strobe_filter.sv
`timescale 1ns/1ns

module strobe_filter (
   input  logic CLOCK_100K,
   input  logic reset,
   input  logic strobe_raw,
   output logic strobe_level,
   output logic row_step
);

   // Debounce states, first letter is the accepted level
   typedef enum logic [1:0] {
      DB_LL = 2'd0,
      DB_LH = 2'd1,
      DB_HH = 2'd2,
      DB_HL = 2'd3
   } db_state_t;

   logic      sync_1;
   logic      sync_2;
   db_state_t db_state;
   db_state_t db_next;
   logic      level_d;

   // Opto strobe is asynchronous to the core
   always_ff @(posedge CLOCK_100K or posedge reset) begin
      if (reset) begin
         sync_1 <= 1'b0;
         sync_2 <= 1'b0;
      end else begin
         sync_1 <= strobe_raw;
         sync_2 <= sync_1;
      end
   end

   // New level must be seen on two edges in a row
   always_comb begin
      db_next = db_state;
      unique case (db_state)
         DB_LL: if (sync_2) db_next = DB_LH;
         DB_LH: db_next = sync_2 ? DB_HH : DB_LL;
         DB_HH: if (!sync_2) db_next = DB_HL;
         DB_HL: db_next = sync_2 ? DB_HH : DB_LL;
         default: db_next = DB_LL;
      endcase
   end

   always_ff @(posedge CLOCK_100K or posedge reset) begin
      if (reset) begin
         db_state     <= DB_LL;
         strobe_level <= 1'b0;
         level_d      <= 1'b0;
      end else begin
         db_state     <= db_next;
         strobe_level <= (db_state == DB_HH) || (db_state == DB_HL);
         level_d      <= strobe_level;
      end
   end

   // One step per mirror sweep
   assign row_step = strobe_level & ~level_d;

endmodule

//--- src/row_sequencer.sv
`timescale 1ns/1ns

module row_sequencer (
   input  logic                        CLOCK_100K,
   input  logic                        reset,
   input  logic                        row_step,
   output projector_pkg::row_status_t  row_status,
   output projector_pkg::mirror_drive_t mirror
);

   projector_pkg::seq_state_t state;
   projector_pkg::row_t       row_q;
   projector_pkg::row_t       ret_cnt;
   projector_pkg::row_t       hold_cnt;
   projector_pkg::row_t       head_cnt;
   logic                      dac_wr;

   // Phase machine, advances once per filtered strobe
   always_ff @(posedge CLOCK_100K or posedge reset) begin
      if (reset) begin
         // Start in return so the mirror settles first
         state    <= projector_pkg::SEQ_RETURN;
         row_q    <= '0;
         ret_cnt  <= '0;
         hold_cnt <= '0;
         head_cnt <= '0;
      end else if (row_step) begin
         unique case (state)
            projector_pkg::SEQ_DISPLAY: begin
               if (row_q == projector_pkg::row_t'(projector_pkg::NUM_ROWS - 1)) begin
                  row_q    <= '0;
                  ret_cnt  <= projector_pkg::row_t'(projector_pkg::NUM_ROWS - 1);
                  hold_cnt <= '0;
                  head_cnt <= '0;
                  state    <= projector_pkg::SEQ_RETURN;
               end else begin
                  row_q <= row_q + 8'd1;
               end
            end
            projector_pkg::SEQ_RETURN: begin
               // Counter parks at zero when leaving
               if (ret_cnt == '0) begin
                  state <= projector_pkg::SEQ_HOLD;
               end else begin
                  ret_cnt <= ret_cnt - 8'd1;
               end
            end
            projector_pkg::SEQ_HOLD: begin
               hold_cnt <= hold_cnt + 8'd1;
               if (hold_cnt == projector_pkg::row_t'(projector_pkg::HOLD_STEPS)) begin
                  state <= projector_pkg::SEQ_HEADSTART;
               end
            end
            projector_pkg::SEQ_HEADSTART: begin
               head_cnt <= head_cnt + 8'd1;
               if (head_cnt == projector_pkg::row_t'(projector_pkg::HEADSTART_STEPS)) begin
                  state <= projector_pkg::SEQ_DISPLAY;
               end
            end
            default: begin
               state <= projector_pkg::SEQ_RETURN;
            end
         endcase
      end
   end

   // DAC write strobe inverts on every clock edge
   always_ff @(posedge CLOCK_100K or posedge reset) begin
      if (reset) begin
         dac_wr <= 1'b0;
      end else begin
         dac_wr <= ~dac_wr;
      end
   end

   assign row_status.row        = row_q;
   assign row_status.displaying = (state == projector_pkg::SEQ_DISPLAY);

   // Raw ramp, headstart offset keeps display above the return slope
   assign mirror.ramp   = projector_pkg::mirror_addr_t'(row_q)
                        + projector_pkg::mirror_addr_t'(head_cnt)
                        + projector_pkg::mirror_addr_t'(ret_cnt);
   assign mirror.dac_wr = dac_wr;

endmodule

//--- src/column_scanner.sv
`timescale 1ns/1ns

module column_scanner (
   input  logic                       CLOCK_100K,
   input  logic                       reset,
   input  projector_pkg::row_status_t row_status,
   input  projector_pkg::pixel_t      pixel_data,
   output projector_pkg::fb_addr_t    fb_address,
   output projector_pkg::laser_level_t laser
);

   projector_pkg::row_t  row_prev;
   projector_pkg::col_t  col;
   logic [$clog2(projector_pkg::X_SETTLE_CYCLES + 1) - 1:0] settle_cnt;
   logic                 settling;
   logic                 row_done;
   logic                 blank;
   projector_pkg::fb_addr_t flipped_row;
   projector_pkg::fb_addr_t row_base;

   // Row change detection
   always_ff @(posedge CLOCK_100K or posedge reset) begin
      if (reset) begin
         row_prev <= '0;
      end else begin
         row_prev <= row_status.row;
      end
   end

   assign settling = settle_cnt < projector_pkg::X_SETTLE_CYCLES;
   assign row_done = col >= projector_pkg::col_t'(projector_pkg::NUM_COLS);

   // Settle first, then sweep once across the row and park at the end
   always_ff @(posedge CLOCK_100K or posedge reset) begin
      if (reset) begin
         col        <= '0;
         settle_cnt <= '0;
      end else if (settling) begin
         settle_cnt <= settle_cnt + 1'b1;
      end else if (row_prev != row_status.row) begin
         col        <= '0;
         settle_cnt <= '0;
      end else if (!row_done) begin
         col <= col + 9'd1;
      end
   end

   // Frame is stored bottom row first
   assign flipped_row = projector_pkg::fb_addr_t'(projector_pkg::NUM_ROWS - 1)
                      - projector_pkg::fb_addr_t'(row_status.row);
   assign row_base    = flipped_row * projector_pkg::fb_addr_t'(projector_pkg::NUM_COLS);
   assign fb_address  = projector_pkg::FB_BASE + row_base + projector_pkg::fb_addr_t'(col);

   // Laser off outside the visible part of the sweep
   assign blank = !row_status.displaying || settling || row_done || reset;
   assign laser = blank ? '0 : pixel_data[7:6];

endmodule

//--- src/laser_projector.sv
`timescale 1ns/1ns

module laser_projector (
   input  logic                         CLOCK_100K,
   input  logic                         reset,
   input  logic                         strobe_raw,
   input  projector_pkg::pixel_t        pixel_data,
   output logic                         strobe_level,
   output projector_pkg::row_status_t   row_status,
   output projector_pkg::mirror_drive_t mirror,
   output projector_pkg::fb_addr_t      fb_address,
   output projector_pkg::laser_level_t  laser
);

   // One pulse per x-axis sweep
   logic row_step;

   strobe_filter u_strobe_filter (
      .CLOCK_100K   (CLOCK_100K),
      .reset        (reset),
      .strobe_raw   (strobe_raw),
      .strobe_level (strobe_level),
      .row_step     (row_step)
   );

   row_sequencer u_row_sequencer (
      .CLOCK_100K (CLOCK_100K),
      .reset      (reset),
      .row_step   (row_step),
      .row_status (row_status),
      .mirror     (mirror)
   );

   // Framebuffer read is combinational, address out and pixel back
   column_scanner u_column_scanner (
      .CLOCK_100K (CLOCK_100K),
      .reset      (reset),
      .row_status (row_status),
      .pixel_data (pixel_data),
      .fb_address (fb_address),
      .laser      (laser)
   );

endmodule

//--- sim/laser_projector_chk.sv
`timescale 1ns/1ns

module laser_projector_chk (
   input logic                         CLOCK_100K,
   input logic                         reset,
   input projector_pkg::row_status_t   row_status,
   input projector_pkg::mirror_drive_t mirror,
   input projector_pkg::fb_addr_t      fb_address,
   input projector_pkg::laser_level_t  laser
);

   // Read by the testbench summary
   int fail_count = 0;

   laser_only_on_display: assert property (
      @(posedge CLOCK_100K) disable iff (reset)
      (laser != '0) |-> row_status.displaying
   ) else begin
      fail_count++;
      $error("laser lit while the sequencer is not displaying");
   end

   // First edge after reset has no prior toggle to compare with
   dac_wr_toggles: assert property (
      @(posedge CLOCK_100K) disable iff (reset)
      $past(!reset) |-> (mirror.dac_wr != $past(mirror.dac_wr))
   ) else begin
      fail_count++;
      $error("DAC write strobe held its value for two cycles");
   end

   fb_address_in_frame: assert property (
      @(posedge CLOCK_100K) disable iff (reset)
      (fb_address >= projector_pkg::FB_BASE) &&
      (fb_address <= projector_pkg::FB_BASE +
         projector_pkg::fb_addr_t'(projector_pkg::NUM_ROWS * projector_pkg::NUM_COLS))
   ) else begin
      fail_count++;
      $error("framebuffer address outside the frame");
   end

endmodule

bind laser_projector laser_projector_chk chk0 (
   .CLOCK_100K (CLOCK_100K),
   .reset      (reset),
   .row_status (row_status),
   .mirror     (mirror),
   .fb_address (fb_address),
   .laser      (laser)
);

//--- sim/laser_projector_tb.sv
`timescale 1ns/1ns

module laser_projector_tb;

   localparam int CLK_PERIOD_NS = 40;
   localparam int STROBE_CYCLES = 12;
   localparam int LONG_GAP_CYCLES = 350;
   localparam int SCAN_ROWS = 3;
   // Ramp offset while displaying and steps from reset to first display
   localparam int DISPLAY_OFFSET = projector_pkg::HEADSTART_STEPS + 1;
   localparam int STARTUP_STEPS = 2 + projector_pkg::HOLD_STEPS + DISPLAY_OFFSET;
   localparam int WATCHDOG_NS = 2 * 900 * STROBE_CYCLES * CLK_PERIOD_NS;

   logic                         CLOCK_100K = 1'b0;
   logic                         reset;
   logic                         strobe_raw;
   projector_pkg::pixel_t        pixel_data;
   logic                         strobe_level;
   projector_pkg::row_status_t   row_status;
   projector_pkg::mirror_drive_t mirror;
   projector_pkg::fb_addr_t      fb_address;
   projector_pkg::laser_level_t  laser;

   projector_pkg::pixel_t pixel_mask;
   int                    n_checks;
   int                    n_errors;
   int                    exp_row;

   always #(CLK_PERIOD_NS / 2) CLOCK_100K = ~CLOCK_100K;

   laser_projector dut0 (
      .CLOCK_100K   (CLOCK_100K),
      .reset        (reset),
      .strobe_raw   (strobe_raw),
      .pixel_data   (pixel_data),
      .strobe_level (strobe_level),
      .row_status   (row_status),
      .mirror       (mirror),
      .fb_address   (fb_address),
      .laser        (laser)
   );

   // Framebuffer model, pattern folds in every address byte
   function automatic projector_pkg::pixel_t model_pixel(input projector_pkg::fb_addr_t addr,
                                                         input projector_pkg::pixel_t mask);
      return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ mask;
   endfunction

   assign pixel_data = model_pixel(fb_address, pixel_mask);

   function automatic projector_pkg::row_status_t make_status(input int row, input logic disp);
      projector_pkg::row_status_t s;
      s.row        = projector_pkg::row_t'(row);
      s.displaying = disp;
      return s;
   endfunction

   task automatic note_failure(input string what);
      n_errors++;
      $display("ERROR: %s", what);
   endtask

   task automatic compare_level(input string test, input string what, input logic exp,
                                input logic act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH %s %s expected %0b, actual %0b", test, what, exp, act);
      end
   endtask

   task automatic compare_status(input string test, input projector_pkg::row_status_t exp,
                                 input projector_pkg::row_status_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH %s row_status expected row %0d disp %0b, actual row %0d disp %0b",
                  test, exp.row, exp.displaying, act.row, act.displaying);
      end
   endtask

   task automatic compare_ramp(input string test, input projector_pkg::mirror_addr_t exp,
                               input projector_pkg::mirror_addr_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH %s ramp expected %0d, actual %0d", test, exp, act);
      end
   endtask

   task automatic compare_address(input string test, input projector_pkg::fb_addr_t exp,
                                  input projector_pkg::fb_addr_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH %s fb_address expected %h, actual %h", test, exp, act);
      end
   endtask

   task automatic compare_laser(input string test, input projector_pkg::laser_level_t exp,
                                input projector_pkg::laser_level_t act);
      n_checks++;
      if (act !== exp) begin
         n_errors++;
         $display("MISMATCH %s laser expected %0d, actual %0d", test, exp, act);
      end
   endtask

   task automatic report_test(input string name, input int err_start);
      $display("test %s done, %0d errors", name, n_errors - err_start);
   endtask

   // One opto sweep, glitches land mid-high and mid-low
   task automatic send_strobe(input bit glitchy);
      for (int i = 0; i < STROBE_CYCLES; i++) begin
         @(negedge CLOCK_100K);
         if (i < STROBE_CYCLES / 2) begin
            strobe_raw = !(glitchy && i == 2);
         end else begin
            strobe_raw = glitchy && i == 9;
         end
      end
   endtask

   task automatic test_reset();
      int   err_start;
      logic exp_wr;
      err_start = n_errors;
      reset = 1'b1;
      repeat (5) @(posedge CLOCK_100K);
      @(negedge CLOCK_100K);
      reset = 1'b0;
      @(negedge CLOCK_100K);
      compare_laser("reset", '0, laser);
      compare_status("reset", make_status(0, 1'b0), row_status);
      compare_ramp("reset", '0, mirror.ramp);
      // Strobe is 0 in reset and has inverted once since the release
      exp_wr = 1'b1;
      compare_level("reset", "dac_wr", exp_wr, mirror.dac_wr);
      for (int i = 0; i < 8; i++) begin
         @(negedge CLOCK_100K);
         exp_wr = ~exp_wr;
         compare_level("reset", "dac_wr", exp_wr, mirror.dac_wr);
      end
      report_test("reset", err_start);
   endtask

   task automatic test_glitch();
      int err_start;
      err_start = n_errors;
      for (int g = 0; g < 5; g++) begin
         @(negedge CLOCK_100K);
         strobe_raw = 1'b1;
         @(negedge CLOCK_100K);
         strobe_raw = 1'b0;
         for (int i = 0; i < 6; i++) begin
            @(negedge CLOCK_100K);
            compare_level("glitch", "strobe_level", 1'b0, strobe_level);
         end
      end
      compare_ramp("glitch", '0, mirror.ramp);
      compare_status("glitch", make_status(0, 1'b0), row_status);
      report_test("glitch", err_start);
   endtask

   task automatic test_startup();
      int err_start;
      int base;
      err_start = n_errors;
      // Return and hold steps keep the ramp at zero
      base = projector_pkg::HOLD_STEPS + 2;
      for (int k = 1; k <= STARTUP_STEPS; k++) begin
         send_strobe(k % 3 == 0);
         compare_ramp("startup", (k <= base) ? '0 : projector_pkg::mirror_addr_t'(k - base),
                      mirror.ramp);
         compare_status("startup", make_status(0, k == STARTUP_STEPS), row_status);
      end
      exp_row = 0;
      report_test("startup", err_start);
   endtask

   task automatic test_row_scan();
      int                          err_start;
      int                          lit;
      int                          col;
      projector_pkg::fb_addr_t     row_base;
      projector_pkg::pixel_t       pix;
      err_start = n_errors;
      for (int r = 0; r < SCAN_ROWS; r++) begin
         send_strobe(1'b0);
         exp_row++;
         compare_status("row_scan", make_status(exp_row, 1'b1), row_status);
         compare_ramp("row_scan", projector_pkg::mirror_addr_t'(exp_row + DISPLAY_OFFSET),
                      mirror.ramp);
         // Bottom row sits first in memory
         row_base = projector_pkg::FB_BASE + projector_pkg::fb_addr_t'(
                    (projector_pkg::NUM_ROWS - 1 - exp_row) * projector_pkg::NUM_COLS);
         lit = 0;
         for (int c = 0; c < LONG_GAP_CYCLES; c++) begin
            @(negedge CLOCK_100K);
            col = int'(fb_address - row_base);
            if (laser !== '0) begin
               lit++;
               pix = model_pixel(fb_address, pixel_mask);
               compare_laser("row_scan", pix[7:6], laser);
               if (col >= projector_pkg::NUM_COLS) begin
                  note_failure("row_scan: laser lit past the end of the row");
               end
            end
         end
         if (lit == 0) begin
            note_failure("row_scan: laser never lit during the row");
         end
         compare_laser("row_scan", '0, laser);
         compare_address("row_scan", row_base + projector_pkg::NUM_COLS, fb_address);
      end
      report_test("row_scan", err_start);
   endtask

   task automatic test_frame_wrap();
      int err_start;
      err_start = n_errors;
      while (exp_row < projector_pkg::NUM_ROWS - 1) begin
         send_strobe(1'b0);
         exp_row++;
         compare_status("frame_wrap", make_status(exp_row, 1'b1), row_status);
         compare_ramp("frame_wrap", projector_pkg::mirror_addr_t'(exp_row + DISPLAY_OFFSET),
                      mirror.ramp);
      end
      // Last display row starts the mirror return
      send_strobe(1'b0);
      exp_row = 0;
      compare_status("frame_wrap", make_status(0, 1'b0), row_status);
      compare_ramp("frame_wrap", projector_pkg::mirror_addr_t'(projector_pkg::NUM_ROWS - 1),
                   mirror.ramp);
      for (int i = 1; i <= projector_pkg::NUM_ROWS; i++) begin
         send_strobe(i % 2 == 1);
         compare_ramp("frame_wrap",
                      (i >= projector_pkg::NUM_ROWS - 1) ? '0 :
                      projector_pkg::mirror_addr_t'(projector_pkg::NUM_ROWS - 1 - i),
                      mirror.ramp);
         compare_status("frame_wrap", make_status(0, 1'b0), row_status);
      end
      // Hold, then headstart climbs to the display offset
      send_strobe(1'b0);
      compare_ramp("frame_wrap", '0, mirror.ramp);
      for (int j = 1; j <= DISPLAY_OFFSET; j++) begin
         send_strobe(1'b0);
         compare_ramp("frame_wrap", projector_pkg::mirror_addr_t'(j), mirror.ramp);
         compare_status("frame_wrap", make_status(0, j == DISPLAY_OFFSET), row_status);
      end
      report_test("frame_wrap", err_start);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the tests did not finish within the watchdog time");
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(88));
      pixel_mask = projector_pkg::pixel_t'($urandom);
      reset      = 1'b1;
      strobe_raw = 1'b0;
      n_checks   = 0;
      n_errors   = 0;
      exp_row    = 0;
      test_reset();
      test_glitch();
      test_startup();
      test_row_scan();
      test_frame_wrap();
      $display("%0d checks, %0d errors, %0d assertion failures",
               n_checks, n_errors, dut0.chk0.fail_count);
      if (n_errors == 0 && dut0.chk0.fail_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
src/projector_pkg.sv
src/strobe_filter.sv
src/row_sequencer.sv
src/column_scanner.sv
src/laser_projector.sv
sim/laser_projector_chk.sv
sim/laser_projector_tb.sv
